// ==== rename_macros.svh ====
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// --------------------
// Register file sizes
// --------------------

// MIPS architectural registers, r0 hardwired to zero
`define NUM_ARCH_REGS 32

// Physical tags shared by the whole core
`define NUM_PHYS_REGS 64

// Width of one physical tag
`define PHYS_TAG_BITS 6

// --------------------
// Reset fill of the free list
// --------------------

// Tags 32..63 start out free, 0..31 hold the identity mapping
`define NUM_FREE_INIT 32

`endif

// ==== renamePkg.sv ====
`default_nettype none

`include "rename_macros.svh"

package renamePkg;

    // Architectural register number
    typedef logic [$clog2(`NUM_ARCH_REGS)-1:0] archRegT;

    // Physical register tag
    typedef logic [`PHYS_TAG_BITS-1:0] physTagT;

    // Opcodes the rename stage tells apart
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDI    = 6'h08,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcodeT;

    typedef struct packed {
        logic [5:0] opcode;
        archRegT    rs;
        archRegT    rt;
        archRegT    rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormatT;

    typedef struct packed {
        logic [5:0]  opcode;
        archRegT     rs;
        archRegT     rt;
        logic [15:0] immediate;
    } iFormatT;

    // Same 32 bits, viewed by format
    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrWordT;

endpackage

`default_nettype wire

// ==== initCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module initCounter (
    input  wire                CLK,
    input  wire                rstN,
    input  wire                run,
    output renamePkg::physTagT initTag,
    output logic               push,
    output logic               done
);

    import renamePkg::*;

    localparam int CNT_BITS = $clog2(`NUM_FREE_INIT);

    logic [CNT_BITS-1:0] count;

    assign push = run;
    assign done = run && (count == CNT_BITS'(`NUM_FREE_INIT - 1));

    // First free tag sits right above the identity-mapped ones
    assign initTag = physTagT'(`NUM_FREE_INIT) + physTagT'(count);

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            count <= '0;
        end else if (done) begin
            count <= '0;
        end else if (run) begin
            count <= count + CNT_BITS'(1);
        end
    end

endmodule

`default_nettype wire

// ==== instrFields.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrFields (
    input  wire renamePkg::instrWordT instrWord,
    output renamePkg::archRegT     srcA,
    output renamePkg::archRegT     srcB,
    output renamePkg::archRegT     dest,
    output logic                   writesReg
);

    import renamePkg::*;

    opcodeT opcode;

    // Opcode field is in the same place for both formats
    assign opcode = opcodeT'(instrWord.r.opcode);

    always_comb begin
        srcA = instrWord.r.rs;
        srcB = instrWord.r.rt;
        dest = '0;
        case (opcode)
            OP_SPECIAL: begin
                dest = instrWord.r.rd;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW: begin
                // I-format, rt is the target
                srcA = instrWord.i.rs;
                srcB = '0;
                dest = instrWord.i.rt;
            end
            OP_SW, OP_BEQ, OP_BNE: begin
                srcA = instrWord.i.rs;
                srcB = instrWord.i.rt;
                dest = '0;
            end
            default: begin
                dest = '0;
            end
        endcase
    end

    // r0 as target means nothing to rename
    assign writesReg = (dest != '0);

endmodule

`default_nettype wire

// ==== aliasTable.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module aliasTable (
    input  wire                    CLK,
    input  wire                    rstN,
    input  wire renamePkg::archRegT srcA,
    input  wire renamePkg::archRegT srcB,
    input  wire renamePkg::archRegT dest,
    output renamePkg::physTagT     tagA,
    output renamePkg::physTagT     tagB,
    output renamePkg::physTagT     oldTag,
    input  wire                    write,
    input  wire renamePkg::physTagT newTag
);

    import renamePkg::*;

    // Speculative front-end mapping
    physTagT mapTable [`NUM_ARCH_REGS];

    // Three combinational read ports
    assign tagA   = mapTable[srcA];
    assign tagB   = mapTable[srcB];
    assign oldTag = mapTable[dest];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            // Identity map, r maps to tag r
            for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
                mapTable[r] <= physTagT'(r);
            end
        end else if (write && (dest != '0)) begin
            mapTable[dest] <= newTag;
        end
    end

endmodule

`default_nettype wire

// ==== freeList.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module freeList #(
    parameter int DEPTH = `NUM_PHYS_REGS
) (
    input  wire                    CLK,
    input  wire                    rstN,
    input  wire                    push,
    input  wire renamePkg::physTagT pushTag,
    input  wire                    pop,
    output renamePkg::physTagT     headTag,
    output logic                   empty
);

    import renamePkg::*;

    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    physTagT             tags [DEPTH];
    logic [PTR_BITS-1:0] headPtr;
    logic [PTR_BITS-1:0] tailPtr;
    logic [CNT_BITS-1:0] count;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + PTR_BITS'(1);
    endfunction

    assign headTag = tags[headPtr];
    assign empty   = (count == '0);

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge CLK) begin
        if (push) begin
            tags[tailPtr] <= pushTag;
        end
    end

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (pop) begin
                headPtr <= nextPtr(headPtr);
            end
            // Push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + CNT_BITS'(1);
            end else if (pop && !push) begin
                count <= count - CNT_BITS'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== renameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module renameControl (
    input  wire                    CLK,
    input  wire                    rstN,
    input  wire                    instrReq,
    output logic                   instrAck,
    output logic                   uopReq,
    input  wire                    uopAck,
    input  wire                    initDone,
    output logic                   initRun,
    input  wire                    writesReg,
    input  wire                    listEmpty,
    output logic                   renameNow,
    input  wire renamePkg::physTagT srcA,
    input  wire renamePkg::physTagT srcB,
    input  wire renamePkg::physTagT newTag,
    input  wire renamePkg::physTagT oldTag,
    output renamePkg::physTagT     uopSrcA,
    output renamePkg::physTagT     uopSrcB,
    output renamePkg::physTagT     uopDest,
    output renamePkg::physTagT     uopOldDest,
    output logic                   uopWrites
);

    localparam logic [1:0] INIT    = 2'd0;
    localparam logic [1:0] IDLE    = 2'd1;
    localparam logic [1:0] RELEASE = 2'd2;
    localparam logic [1:0] DRAIN   = 2'd3;

    logic [1:0] state;

    assign initRun = (state == INIT);

    // Accept needs a free tag unless nothing gets written
    assign renameNow = (state == IDLE) && instrReq && (!writesReg || !listEmpty);

    // --------------------
    // Handshake FSM
    // --------------------
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            state    <= INIT;
            instrAck <= 1'b0;
            uopReq   <= 1'b0;
        end else begin
            case (state)
                INIT: begin
                    if (initDone) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (renameNow) begin
                        instrAck <= 1'b1;
                        uopReq   <= 1'b1;
                        state    <= RELEASE;
                    end
                end
                RELEASE: begin
                    // Both sides release on their own
                    if (!instrReq) begin
                        instrAck <= 1'b0;
                    end
                    if (uopAck) begin
                        uopReq <= 1'b0;
                    end
                    if (!instrAck && !uopReq) begin
                        state <= uopAck ? DRAIN : IDLE;
                    end
                end
                DRAIN: begin
                    // Sink still holding ack from the last uop
                    if (!uopAck) begin
                        state <= IDLE;
                    end
                end
                default: state <= INIT;
            endcase
        end
    end

    // --------------------
    // Uop payload
    // --------------------
    always_ff @(posedge CLK) begin
        if (renameNow) begin
            uopSrcA    <= srcA;
            uopSrcB    <= srcB;
            uopDest    <= writesReg ? newTag : '0;
            uopOldDest <= oldTag;
            uopWrites  <= writesReg;
        end
    end

endmodule

`default_nettype wire

// ==== renameTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module renameTop (
    input  wire                    CLK,
    input  wire                    rstN,
    input  wire                    instrReq,
    input  wire renamePkg::instrWordT instrWord,
    output logic                   instrAck,
    output logic                   uopReq,
    input  wire                    uopAck,
    output renamePkg::physTagT     uopSrcA,
    output renamePkg::physTagT     uopSrcB,
    output renamePkg::physTagT     uopDest,
    output renamePkg::physTagT     uopOldDest,
    output logic                   uopWrites,
    input  wire                    freeValid,
    input  wire renamePkg::physTagT freeTag
);

    import renamePkg::*;

    // Decoded architectural fields
    archRegT archSrcA;
    archRegT archSrcB;
    archRegT archDest;
    logic    writesReg;

    // F-RAT read side
    physTagT tagA;
    physTagT tagB;
    physTagT oldTag;

    // Free list and reset fill
    physTagT headTag;
    logic    listEmpty;
    logic    listPush;
    physTagT listPushTag;
    logic    initRun;
    logic    initPush;
    logic    initDone;
    physTagT initTag;

    logic    renameNow;
    logic    allocNow;

    // --------------------
    // Push source select and allocate strobe
    // --------------------

    // Retire pushes are ignored while the fill is running
    assign listPush    = initRun ? initPush : freeValid;
    assign listPushTag = initRun ? initTag : freeTag;

    // Only a real destination takes a tag and updates the table
    assign allocNow = renameNow & writesReg;

    initCounter initCounter_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .run     (initRun),
        .initTag (initTag),
        .push    (initPush),
        .done    (initDone)
    );

    instrFields instrFields_i (
        .instrWord (instrWord),
        .srcA      (archSrcA),
        .srcB      (archSrcB),
        .dest      (archDest),
        .writesReg (writesReg)
    );

    aliasTable aliasTable_i (
        .CLK    (CLK),
        .rstN   (rstN),
        .srcA   (archSrcA),
        .srcB   (archSrcB),
        .dest   (archDest),
        .tagA   (tagA),
        .tagB   (tagB),
        .oldTag (oldTag),
        .write  (allocNow),
        .newTag (headTag)
    );

    freeList #(
        .DEPTH (`NUM_PHYS_REGS)
    ) freeList_i (
        .CLK     (CLK),
        .rstN    (rstN),
        .push    (listPush),
        .pushTag (listPushTag),
        .pop     (allocNow),
        .headTag (headTag),
        .empty   (listEmpty)
    );

    renameControl renameControl_i (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrReq   (instrReq),
        .instrAck   (instrAck),
        .uopReq     (uopReq),
        .uopAck     (uopAck),
        .initDone   (initDone),
        .initRun    (initRun),
        .writesReg  (writesReg),
        .listEmpty  (listEmpty),
        .renameNow  (renameNow),
        .srcA       (tagA),
        .srcB       (tagB),
        .newTag     (headTag),
        .oldTag     (oldTag),
        .uopSrcA    (uopSrcA),
        .uopSrcB    (uopSrcB),
        .uopDest    (uopDest),
        .uopOldDest (uopOldDest),
        .uopWrites  (uopWrites)
    );

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int HALF_PERIOD = 10
) (
    output logic CLK
);

    // 20 ns period with the default half period
    initial begin
        CLK = 1'b0;
        forever #(HALF_PERIOD) CLK = ~CLK;
    end

endmodule

`default_nettype wire

// ==== rename_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module rename_properties (
    input wire                     CLK,
    input wire                     rstN,
    input wire                     instrReq,
    input wire                     instrAck,
    input wire                     uopReq,
    input wire                     uopAck,
    input wire renamePkg::physTagT uopSrcA,
    input wire renamePkg::physTagT uopSrcB,
    input wire renamePkg::physTagT uopDest,
    input wire renamePkg::physTagT uopOldDest,
    input wire                     uopWrites,
    input wire                     listPush,
    input wire                     allocNow,
    input wire                     listEmpty
);

    import renamePkg::*;

    int assertFails = 0;
    int occupancy;

    // Shadow occupancy of the free list
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(listPush) - int'(allocNow);
        end
    end

    // --------------------
    // Input handshake
    // --------------------
    ackNeedsReq: assert property (@(posedge CLK) disable iff (!rstN)
        $rose(instrAck) |-> $past(instrReq))
        else begin
            $error("instrAck rose without instrReq");
            assertFails++;
        end

    ackAfterUopDone: assert property (@(posedge CLK) disable iff (!rstN)
        $rose(instrAck) |-> !$past(uopReq) && !$past(uopAck))
        else begin
            $error("instrAck rose while the previous uop was still open");
            assertFails++;
        end

    // --------------------
    // Output handshake
    // --------------------
    uopHeld: assert property (@(posedge CLK) disable iff (!rstN)
        uopReq && !uopAck |=> uopReq &&
            $stable({uopSrcA, uopSrcB, uopDest, uopOldDest, uopWrites}))
        else begin
            $error("uopReq or its payload changed before uopAck");
            assertFails++;
        end

    // Free list bounds
    noPushWhenFull: assert property (@(posedge CLK) disable iff (!rstN)
        listPush |-> occupancy < `NUM_PHYS_REGS)
        else begin
            $error("free list pushed while full");
            assertFails++;
        end

    noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!rstN)
        allocNow |-> occupancy > 0)
        else begin
            $error("free list popped while empty");
            assertFails++;
        end

endmodule

bind renameTop rename_properties props (
    .CLK        (CLK),
    .rstN       (rstN),
    .instrReq   (instrReq),
    .instrAck   (instrAck),
    .uopReq     (uopReq),
    .uopAck     (uopAck),
    .uopSrcA    (uopSrcA),
    .uopSrcB    (uopSrcB),
    .uopDest    (uopDest),
    .uopOldDest (uopOldDest),
    .uopWrites  (uopWrites),
    .listPush   (listPush),
    .allocNow   (allocNow),
    .listEmpty  (listEmpty)
);

`default_nettype wire

// ==== tbRename.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_macros.svh"

module tbRename;

    import renamePkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int STALL_CYCLES = 30;

    logic      CLK;
    logic      rstN;
    logic      instrReq;
    instrWordT instrWord;
    logic      instrAck;
    logic      uopReq;
    logic      uopAck;
    physTagT   uopSrcA;
    physTagT   uopSrcB;
    physTagT   uopDest;
    physTagT   uopOldDest;
    logic      uopWrites;
    logic      freeValid;
    physTagT   freeTag;

    // Stimulus table, one column per queue
    string     testNames[$];
    instrWordT testWords[$];
    int        testReps[$];
    int        testFree[$];
    bit        testStall[$];
    int        testDelay[$];
    bit        tableReady = 1'b0;

    // Reference model of the F-RAT and the free list
    physTagT   modelMap [`NUM_ARCH_REGS];
    physTagT   modelFree[$];

    int errorCount = 0;
    int checkCount = 0;
    int runCount   = 0;
    int uopCount   = 0;
    int cycleCount = 0;
    int ackHold    = 0;
    logic uopReqLast = 1'b0;

    tbClock clockGen_i (
        .CLK (CLK)
    );

    renameTop renameTop_i (
        .CLK        (CLK),
        .rstN       (rstN),
        .instrReq   (instrReq),
        .instrWord  (instrWord),
        .instrAck   (instrAck),
        .uopReq     (uopReq),
        .uopAck     (uopAck),
        .uopSrcA    (uopSrcA),
        .uopSrcB    (uopSrcB),
        .uopDest    (uopDest),
        .uopOldDest (uopOldDest),
        .uopWrites  (uopWrites),
        .freeValid  (freeValid),
        .freeTag    (freeTag)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic instrWordT makeRType(input int rs, input int rt, input int rd);
        instrWordT w;
        w.r.opcode = 6'h00;
        w.r.rs     = archRegT'(rs);
        w.r.rt     = archRegT'(rt);
        w.r.rd     = archRegT'(rd);
        w.r.shamt  = 5'd0;
        w.r.funct  = 6'h20;
        return w;
    endfunction

    function automatic instrWordT makeIType(input logic [5:0] op, input int rs, input int rt,
                                            input logic [15:0] imm);
        instrWordT w;
        w.i.opcode    = op;
        w.i.rs        = archRegT'(rs);
        w.i.rt        = archRegT'(rt);
        w.i.immediate = imm;
        return w;
    endfunction

    // Register roles taken straight from the raw bits
    function automatic void decodeRef(input logic [31:0] w, output bit writes,
                                      output archRegT a, output archRegT b, output archRegT d);
        logic [5:0] op;
        op = w[31:26];
        a  = w[25:21];
        b  = w[20:16];
        d  = '0;
        if (op == 6'h00) begin
            d = w[15:11];
        end else if ((op >= 6'h08 && op <= 6'h0F) || op == 6'h23) begin
            b = '0;
            d = w[20:16];
        end
        writes = (d != '0);
    endfunction

    task automatic addTest(input string name, input instrWordT word, input int reps,
                           input int freeBase, input bit stall, input int delay);
        testNames.push_back(name);
        testWords.push_back(word);
        testReps.push_back(reps);
        testFree.push_back(freeBase);
        testStall.push_back(stall);
        testDelay.push_back(delay);
    endtask

    task automatic waitCycle();
        @(posedge CLK);
        #2;
        cycleCount++;
    endtask

    task automatic checkValue(input string test, input string what, input int expected,
                              input int actual);
        checkCount++;
        if (expected != actual) begin
            errorCount++;
            $display("Fail %s: %s expected %0d, actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic pulseFree(input physTagT tag);
        freeValid = 1'b1;
        freeTag   = tag;
        waitCycle();
        freeValid = 1'b0;
        modelFree.push_back(tag);
    endtask

    // Let go of a uopAck still held from the last uop
    task automatic releaseAck(input string test);
        if (uopAck) begin
            repeat (ackHold) begin
                waitCycle();
                checkValue(test, "instrAck while uopAck held", 0, int'(instrAck));
            end
            uopAck = 1'b0;
        end
    endtask

    // One instruction through both handshakes
    task automatic applyOne(input int idx, input int rep);
        string   name;
        bit      writes;
        archRegT a;
        archRegT b;
        archRegT d;
        physTagT expA;
        physTagT expB;
        physTagT expDest;
        physTagT expOld;
        int      delay;
        name = testNames[idx];
        if (testFree[idx] >= 0 && !testStall[idx]) begin
            pulseFree(physTagT'(testFree[idx] + rep));
        end
        instrWord = testWords[idx];
        instrReq  = 1'b1;
        releaseAck(name);
        if (testStall[idx]) begin
            repeat (STALL_CYCLES) begin
                waitCycle();
                checkValue(name, "instrAck while list empty", 0, int'(instrAck));
            end
            pulseFree(physTagT'(testFree[idx] + rep));
        end
        decodeRef(testWords[idx], writes, a, b, d);
        // Sources see the mapping from before this write
        expA    = modelMap[a];
        expB    = modelMap[b];
        expDest = '0;
        expOld  = modelMap[d];
        if (writes) begin
            expDest     = modelFree.pop_front();
            modelMap[d] = expDest;
        end
        while (!instrAck) begin
            waitCycle();
        end
        if (runCount == 0) begin
            checkValue(name, "ack after free list fill", 1,
                       int'(cycleCount > `NUM_FREE_INIT));
        end
        checkValue(name, "uopReq", 1, int'(uopReq));
        checkValue(name, "uopSrcA", int'(expA), int'(uopSrcA));
        checkValue(name, "uopSrcB", int'(expB), int'(uopSrcB));
        checkValue(name, "uopWrites", int'(writes), int'(uopWrites));
        if (writes) begin
            checkValue(name, "uopDest", int'(expDest), int'(uopDest));
            checkValue(name, "uopOldDest", int'(expOld), int'(uopOldDest));
        end
        instrReq = 1'b0;
        delay = (testDelay[idx] < 0) ? int'($urandom % 6) : testDelay[idx];
        repeat (delay) waitCycle();
        uopAck = 1'b1;
        while (uopReq) begin
            waitCycle();
        end
        // Random sinks keep uopAck up into the next request
        if (testDelay[idx] < 0) begin
            ackHold = 1 + int'($urandom % 3);
        end else begin
            uopAck = 1'b0;
        end
        while (instrAck) begin
            waitCycle();
        end
    endtask

    // Count uops by rising uopReq
    always @(negedge CLK) begin
        if (uopReq && !uopReqLast) begin
            uopCount++;
        end
        uopReqLast = uopReq;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int errorsBefore;
        int totalFails;
        void'($urandom(32'h8948));
        rstN      = 1'b0;
        instrReq  = 1'b0;
        instrWord = '0;
        uopAck    = 1'b0;
        freeValid = 1'b0;
        freeTag   = '0;
        for (int r = 0; r < `NUM_ARCH_REGS; r++) begin
            modelMap[r] = physTagT'(r);
        end
        for (int t = 0; t < `NUM_FREE_INIT; t++) begin
            modelFree.push_back(physTagT'(`NUM_FREE_INIT + t));
        end

        // name, word, repeats, first tag to free, stall, uopAck delay
        addTest("addR",      makeRType(1, 2, 3),                1, -1, 1'b0, 0);
        addTest("addChain",  makeRType(3, 1, 4),                1, -1, 1'b0, 2);
        addTest("addiRt",    makeIType(6'h08, 4, 6, 16'h0005),  1, -1, 1'b0, 1);
        addTest("lwRt",      makeIType(6'h23, 6, 7, 16'h0000),  1, -1, 1'b0, 0);
        addTest("swNoDest",  makeIType(6'h2B, 6, 7, 16'h0004),  1, -1, 1'b0, 3);
        addTest("beqNoDest", makeIType(6'h04, 3, 4, 16'hFFF0),  1, -1, 1'b0, 0);
        addTest("bneNoDest", makeIType(6'h05, 7, 6, 16'h0010),  1, -1, 1'b0, 1);
        addTest("addToR0",   makeRType(1, 2, 0),                1, -1, 1'b0, 0);
        addTest("oriToR0",   makeIType(6'h0D, 5, 0, 16'h00FF),  1, -1, 1'b0, 0);
        addTest("addRemap",  makeRType(3, 7, 3),                1, -1, 1'b0, 2);
        addTest("fillChain", makeIType(6'h08, 5, 5, 16'h0001), 27, -1, 1'b0, 0);
        addTest("exhausted", makeIType(6'h08, 3, 8, 16'h0002),  1, 32, 1'b1, 0);
        addTest("randAddiu", makeIType(6'h09, 5, 9, 16'h0003),  4, 37, 1'b0, -1);
        addTest("randBne",   makeIType(6'h05, 9, 5, 16'h0008),  4, -1, 1'b0, -1);
        addTest("randLw",    makeIType(6'h23, 9, 10, 16'h0020), 3, 41, 1'b0, -1);
        tableReady = 1'b1;

        repeat (RESET_CYCLES) waitCycle();
        rstN       = 1'b1;
        cycleCount = 0;
        checkValue("afterReset", "instrAck", 0, int'(instrAck));
        checkValue("afterReset", "uopReq", 0, int'(uopReq));

        foreach (testNames[idx]) begin
            errorsBefore = errorCount;
            for (int rep = 0; rep < testReps[idx]; rep++) begin
                applyOne(idx, rep);
                runCount++;
            end
            $display("Test %s: %0d run(s), %0d mismatch(es)", testNames[idx], testReps[idx],
                     errorCount - errorsBefore);
        end

        releaseAck("lastUop");
        waitCycle();
        checkValue("uopCount", "uops seen", runCount, uopCount);
        totalFails = errorCount + renameTop_i.props.assertFails;
        $display("Runs: %0d, checks: %0d, mismatches: %0d, assertion failures: %0d",
                 runCount, checkCount, errorCount, renameTop_i.props.assertFails);
        if (totalFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        int total;
        int limit;
        wait (tableReady);
        total = 0;
        foreach (testReps[i]) begin
            total += testReps[i];
        end
        limit = RESET_CYCLES + `NUM_FREE_INIT + total * 60;
        repeat (limit) @(posedge CLK);
        $display("Timeout: the handshakes did not finish within %0d cycles", limit);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
renamePkg.sv
initCounter.sv
instrFields.sv
aliasTable.sv
freeList.sv
renameControl.sv
renameTop.sv
tbClock.sv
rename_properties.sv
tbRename.sv

// ==== Makefile ====
# Verilator build and run of the rename stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tbRename -f sources.f -o simRename

# Pass only when the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/simRename +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
